// ==== all.f ====
+incdir+source
source/scaler_pkg.sv
source/skid_buffer.sv
source/gain_combiner.sv
source/gain_scaler_top.sv
dv/gain_scaler_tb.sv

// ==== dv/gain_scaler_tb.sv ====
`timescale 1ns/1ps

`include "scaler_defines.svh"

module gain_scaler_tb;

    localparam int CLOCK_HALF     = 20;
    localparam int DRIVE_DELAY    = 2;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_DIRECTED   = 18;
    localparam int NUM_RANDOM     = 30;
    localparam int NUM_ENTRIES    = NUM_DIRECTED + NUM_RANDOM;

    // One row of stimulus with its expected output
    typedef struct packed {
        scaler_pkg::sample_t sample;
        scaler_pkg::gain_t   gain;
        scaler_pkg::sample_t result;
        logic                overflow;
    } entry_t;

    logic                     i_clock;
    logic                     i_reset;
    logic [`SAMPLE_WIDTH-1:0] i_sample;
    logic                     i_sample_valid;
    logic                     o_sample_ready;
    logic [`GAIN_WIDTH-1:0]   i_gain;
    logic [`SHIFT_WIDTH-1:0]  i_shift;
    logic                     i_gain_valid;
    logic                     o_gain_ready;
    logic [`SAMPLE_WIDTH-1:0] o_result;
    logic                     o_overflow;
    logic                     o_result_valid;
    logic                     i_result_ready;

    entry_t stim_table [NUM_ENTRIES];

    int value_errors;
    int flag_errors;
    int timeout_errors;
    int results_seen;

    gain_scaler_top i_gain_scaler_top (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_sample      (i_sample),
        .i_sample_valid(i_sample_valid),
        .o_sample_ready(o_sample_ready),
        .i_gain        (i_gain),
        .i_shift       (i_shift),
        .i_gain_valid  (i_gain_valid),
        .o_gain_ready  (o_gain_ready),
        .o_result      (o_result),
        .o_overflow    (o_overflow),
        .o_result_valid(o_result_valid),
        .i_result_ready(i_result_ready)
    );

    initial begin
        i_clock = 1'b0;
        forever #CLOCK_HALF i_clock = ~i_clock;
    end

    // Reference model of full product, arithmetic right shift and clamp to sample range
    function automatic scaler_pkg::result_t model_scale(scaler_pkg::sample_t s,
                                                        scaler_pkg::gain_t g);
        scaler_pkg::product_t full;
        scaler_pkg::product_t scaled;
        scaler_pkg::result_t  r;
        full   = scaler_pkg::product_t'(longint'(s) * longint'($signed(g.gain)));
        scaled = full >>> g.shift;
        if (scaled > scaler_pkg::SAMPLE_MAX) begin
            r.value    = scaler_pkg::sample_t'(scaler_pkg::SAMPLE_MAX);
            r.overflow = 1'b1;
        end else if (scaled < scaler_pkg::SAMPLE_MIN) begin
            r.value    = scaler_pkg::sample_t'(scaler_pkg::SAMPLE_MIN);
            r.overflow = 1'b1;
        end else begin
            r.value    = scaler_pkg::sample_t'(scaled);
            r.overflow = 1'b0;
        end
        return r;
    endfunction

    task automatic add_entry(int idx, scaler_pkg::sample_t s,
                             logic signed [`GAIN_WIDTH-1:0] g, logic [`SHIFT_WIDTH-1:0] sh);
        scaler_pkg::result_t expected;
        stim_table[idx].sample     = s;
        stim_table[idx].gain.gain  = g;
        stim_table[idx].gain.shift = sh;
        expected                   = model_scale(s, stim_table[idx].gain);
        stim_table[idx].result     = expected.value;
        stim_table[idx].overflow   = expected.overflow;
    endtask

    task automatic build_table;
        int k;
        add_entry(0, 16'sd1000, 8'sd1, 3'd0);
        // Zero gain
        add_entry(1, 16'sd1234, 8'sd0, 3'd3);
        // Negative gains
        add_entry(2, -16'sd2000, -8'sd3, 3'd1);
        add_entry(3, 16'sd3000, -8'sd7, 3'd2);
        // Every shift count on a negative product
        for (k = 0; k < 8; k++) begin
            add_entry(4 + k, -16'sd1111, 8'sd13, 3'(k));
        end
        // Clamp cases on both sides
        add_entry(12, 16'sd32767, 8'sd127, 3'd0);
        add_entry(13, 16'sh8000, 8'sd127, 3'd0);
        add_entry(14, 16'sh8000, 8'sh80, 3'd7);
        add_entry(15, 16'sd32767, 8'sh80, 3'd7);
        add_entry(16, 16'sd20000, 8'sd2, 3'd0);
        add_entry(17, -16'sd20000, 8'sd2, 3'd1);
        for (k = NUM_DIRECTED; k < NUM_ENTRIES; k++) begin
            add_entry(k, scaler_pkg::sample_t'($urandom), `GAIN_WIDTH'($urandom),
                      `SHIFT_WIDTH'($urandom_range(0, 7)));
        end
    endtask

    task automatic check_value(string name, scaler_pkg::sample_t expected,
                               scaler_pkg::sample_t actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %b actual %b", $time, name, expected, actual);
            flag_errors++;
        end
    endtask

    task automatic check_reset_state;
        @(posedge i_clock);
        repeat (3) begin
            @(negedge i_clock);
            check_flag("o_result_valid", 1'b0, o_result_valid);
            check_flag("o_sample_ready", 1'b0, o_sample_ready);
            check_flag("o_gain_ready", 1'b0, o_gain_ready);
            @(posedge i_clock);
        end
        #DRIVE_DELAY;
        i_reset = 1'b0;
        // Ready is still held low for one cycle
        @(negedge i_clock);
        check_flag("o_result_valid", 1'b0, o_result_valid);
        check_flag("o_sample_ready", 1'b0, o_sample_ready);
        check_flag("o_gain_ready", 1'b0, o_gain_ready);
        @(negedge i_clock);
        check_flag("o_sample_ready", 1'b1, o_sample_ready);
        check_flag("o_gain_ready", 1'b1, o_gain_ready);
        repeat (6) begin
            @(negedge i_clock);
            check_flag("o_result_valid", 1'b0, o_result_valid);
        end
    endtask

    task automatic send_samples;
        int   idx;
        int   gap;
        int   cycles;
        logic accepted;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            gap = $urandom_range(0, 2);
            i_sample_valid = 1'b0;
            repeat (gap) begin
                @(posedge i_clock);
                #DRIVE_DELAY;
            end
            i_sample       = stim_table[idx].sample;
            i_sample_valid = 1'b1;
            cycles   = 0;
            accepted = 1'b0;
            while (!accepted && cycles < TIMEOUT_CYCLES) begin
                @(negedge i_clock);
                accepted = o_sample_ready;
                @(posedge i_clock);
                #DRIVE_DELAY;
                cycles++;
            end
            if (!accepted) begin
                $display("Timeout at %0t: sample %0d was never accepted", $time, idx);
                timeout_errors++;
                i_sample_valid = 1'b0;
                return;
            end
        end
        i_sample_valid = 1'b0;
    endtask

    task automatic send_gains;
        int   idx;
        int   gap;
        int   cycles;
        logic accepted;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            // Long idle stretches let the sample lane run ahead
            if ($urandom_range(0, 5) == 0) begin
                gap = $urandom_range(12, 30);
            end else begin
                gap = $urandom_range(0, 2);
            end
            i_gain_valid = 1'b0;
            repeat (gap) begin
                @(posedge i_clock);
                #DRIVE_DELAY;
            end
            i_gain       = stim_table[idx].gain.gain;
            i_shift      = stim_table[idx].gain.shift;
            i_gain_valid = 1'b1;
            cycles   = 0;
            accepted = 1'b0;
            while (!accepted && cycles < TIMEOUT_CYCLES) begin
                @(negedge i_clock);
                accepted = o_gain_ready;
                @(posedge i_clock);
                #DRIVE_DELAY;
                cycles++;
            end
            if (!accepted) begin
                $display("Timeout at %0t: gain word %0d was never accepted", $time, idx);
                timeout_errors++;
                i_gain_valid = 1'b0;
                return;
            end
        end
        i_gain_valid = 1'b0;
    endtask

    task automatic collect_results;
        int                  idx;
        int                  cycles;
        logic                got;
        logic                stalled;
        scaler_pkg::sample_t held_value;
        logic                held_flag;
        stalled = 1'b0;
        for (idx = 0; idx < NUM_ENTRIES; idx++) begin
            cycles = 0;
            got    = 1'b0;
            while (!got && cycles < TIMEOUT_CYCLES) begin
                i_result_ready = ($urandom_range(0, 3) != 0);
                @(negedge i_clock);
                // A stalled result must still be offered unchanged
                if (stalled) begin
                    check_flag("o_result_valid", 1'b1, o_result_valid);
                    check_value("o_result", held_value, o_result);
                    check_flag("o_overflow", held_flag, o_overflow);
                end
                if (o_result_valid && i_result_ready) begin
                    check_value("o_result", stim_table[idx].result, o_result);
                    check_flag("o_overflow", stim_table[idx].overflow, o_overflow);
                    results_seen++;
                    got     = 1'b1;
                    stalled = 1'b0;
                end else if (o_result_valid) begin
                    stalled    = 1'b1;
                    held_value = o_result;
                    held_flag  = o_overflow;
                end else begin
                    stalled = 1'b0;
                end
                @(posedge i_clock);
                #DRIVE_DELAY;
                cycles++;
            end
            if (!got) begin
                $display("Timeout at %0t: result %0d never came out", $time, idx);
                timeout_errors++;
                i_result_ready = 1'b0;
                return;
            end
        end
        i_result_ready = 1'b0;
    endtask

    // No extra result after the last entry
    task automatic check_drained;
        i_result_ready = 1'b1;
        repeat (10) begin
            @(negedge i_clock);
            check_flag("o_result_valid", 1'b0, o_result_valid);
        end
        i_result_ready = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hd8f5_1516));
        i_reset        = 1'b1;
        i_sample       = '0;
        i_sample_valid = 1'b0;
        i_gain         = '0;
        i_shift        = '0;
        i_gain_valid   = 1'b0;
        i_result_ready = 1'b0;
        value_errors   = 0;
        flag_errors    = 0;
        timeout_errors = 0;
        results_seen   = 0;

        build_table();
        check_reset_state();

        @(posedge i_clock);
        #DRIVE_DELAY;
        fork
            send_samples();
            send_gains();
            collect_results();
        join

        check_drained();

        $display("Checked %0d of %0d results: %0d value errors, %0d flag errors, %0d timeouts",
                 results_seen, NUM_ENTRIES, value_errors, flag_errors, timeout_errors);
        if (value_errors == 0 && flag_errors == 0 && timeout_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the gain stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=gain_scaler_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module gain_scaler_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_NAME"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== source/gain_combiner.sv ====
`timescale 1ns/1ps

module gain_combiner (
    input  logic                i_clock,
    input  logic                i_reset,
    // Sample lane
    input  scaler_pkg::sample_t i_sample,
    input  logic                i_sample_valid,
    output logic                o_sample_ready,
    // Gain lane
    input  scaler_pkg::gain_t   i_gain,
    input  logic                i_gain_valid,
    output logic                o_gain_ready,
    // Result
    output scaler_pkg::result_t o_result,
    output logic                o_result_valid,
    input  logic                i_result_ready
);

    scaler_pkg::product_t product;
    scaler_pkg::product_t shifted;
    scaler_pkg::result_t  next_result;

    logic take;

    // A pair is taken when both heads are present and the result slot frees up
    assign take = i_sample_valid && i_gain_valid && (!o_result_valid || i_result_ready);

    // Both lanes advance together
    assign o_sample_ready = take;
    assign o_gain_ready   = take;

    always_comb begin
        // Sign extend both operands to product width before multiplying
        product = scaler_pkg::product_t'(i_sample) * scaler_pkg::product_t'(i_gain.gain);

        // Arithmetic shift keeps the sign of negative products
        shifted = product >>> i_gain.shift;

        if (shifted > scaler_pkg::SAMPLE_MAX) begin
            next_result.value    = scaler_pkg::sample_t'(scaler_pkg::SAMPLE_MAX);
            next_result.overflow = 1'b1;
        end else if (shifted < scaler_pkg::SAMPLE_MIN) begin
            next_result.value    = scaler_pkg::sample_t'(scaler_pkg::SAMPLE_MIN);
            next_result.overflow = 1'b1;
        end else begin
            next_result.value    = scaler_pkg::sample_t'(shifted);
            next_result.overflow = 1'b0;
        end
    end

    // One-entry result slot
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_result_valid <= 1'b0;
        end else if (take) begin
            o_result_valid <= 1'b1;
        end else if (i_result_ready) begin
            o_result_valid <= 1'b0;
        end
    end

    // Result payload loads only with a new pair
    always_ff @(posedge i_clock) begin
        if (take) begin
            o_result <= next_result;
        end
    end

    // A taken pair is offered on the next cycle
    a_pair_offered: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_sample_ready && o_gain_ready) |=> o_result_valid
    );

    // Stalled result stays put and stays offered
    a_result_stable: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_result_valid && !i_result_ready) |=> (o_result_valid && $stable(o_result))
    );

endmodule

// ==== source/gain_scaler_top.sv ====
`timescale 1ns/1ps

`include "scaler_defines.svh"

module gain_scaler_top (
    input  logic                     i_clock,
    input  logic                     i_reset,
    // Sample stream
    input  logic [`SAMPLE_WIDTH-1:0] i_sample,
    input  logic                     i_sample_valid,
    output logic                     o_sample_ready,
    // Gain stream
    input  logic [`GAIN_WIDTH-1:0]   i_gain,
    input  logic [`SHIFT_WIDTH-1:0]  i_shift,
    input  logic                     i_gain_valid,
    output logic                     o_gain_ready,
    // Scaled output
    output logic [`SAMPLE_WIDTH-1:0] o_result,
    output logic                     o_overflow,
    output logic                     o_result_valid,
    input  logic                     i_result_ready
);

    scaler_pkg::sample_t sample_in;
    scaler_pkg::gain_t   gain_in;

    // Buffer heads toward the combiner
    scaler_pkg::sample_t sample_head;
    logic                sample_head_valid;
    logic                sample_head_ready;
    scaler_pkg::gain_t   gain_head;
    logic                gain_head_valid;
    logic                gain_head_ready;

    scaler_pkg::result_t result;

    // Plain ports into package types
    assign sample_in     = scaler_pkg::sample_t'(i_sample);
    assign gain_in.gain  = i_gain;
    assign gain_in.shift = i_shift;

    skid_buffer #(
        .T_PAYLOAD(scaler_pkg::sample_t)
    ) sample_skid (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_in_data  (sample_in),
        .i_in_valid (i_sample_valid),
        .o_in_ready (o_sample_ready),
        .o_out_data (sample_head),
        .o_out_valid(sample_head_valid),
        .i_out_ready(sample_head_ready)
    );

    skid_buffer #(
        .T_PAYLOAD(scaler_pkg::gain_t)
    ) gain_skid (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_in_data  (gain_in),
        .i_in_valid (i_gain_valid),
        .o_in_ready (o_gain_ready),
        .o_out_data (gain_head),
        .o_out_valid(gain_head_valid),
        .i_out_ready(gain_head_ready)
    );

    gain_combiner combiner (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_sample      (sample_head),
        .i_sample_valid(sample_head_valid),
        .o_sample_ready(sample_head_ready),
        .i_gain        (gain_head),
        .i_gain_valid  (gain_head_valid),
        .o_gain_ready  (gain_head_ready),
        .o_result      (result),
        .o_result_valid(o_result_valid),
        .i_result_ready(i_result_ready)
    );

    // Result struct back out to plain ports
    assign o_result   = result.value;
    assign o_overflow = result.overflow;

endmodule

// ==== source/scaler_defines.svh ====
`ifndef SCALER_DEFINES_SVH
`define SCALER_DEFINES_SVH

// Widths of the gain stage data paths

// Signed audio sample
`define SAMPLE_WIDTH 16

// Signed gain multiplier
`define GAIN_WIDTH 8

// Unsigned right-shift count applied after the multiply
`define SHIFT_WIDTH 3

`endif

// ==== source/scaler_pkg.sv ====
`include "scaler_defines.svh"

package scaler_pkg;

    // Sample lane payload and result value
    typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

    // Gain lane payload
    typedef struct packed {
        logic signed [`GAIN_WIDTH-1:0]  gain;
        logic        [`SHIFT_WIDTH-1:0] shift;
    } gain_t;

    // Product wide enough for any sample times any gain
    typedef logic signed [`SAMPLE_WIDTH+`GAIN_WIDTH-1:0] product_t;

    // Saturated result with its clamp flag
    typedef struct packed {
        sample_t value;
        logic    overflow;
    } result_t;

    // Saturation limits at product width
    localparam product_t SAMPLE_MAX = product_t'(2 ** (`SAMPLE_WIDTH - 1) - 1);
    localparam product_t SAMPLE_MIN = -product_t'(2 ** (`SAMPLE_WIDTH - 1));

endpackage

// ==== source/skid_buffer.sv ====
`timescale 1ns/1ps

module skid_buffer #(
    parameter type T_PAYLOAD = logic [15:0]
) (
    input  logic     i_clock,
    input  logic     i_reset,
    // Upstream side
    input  T_PAYLOAD i_in_data,
    input  logic     i_in_valid,
    output logic     o_in_ready,
    // Downstream side
    output T_PAYLOAD o_out_data,
    output logic     o_out_valid,
    input  logic     i_out_ready
);

    typedef enum logic [1:0] {
        ST_START,
        ST_IDLE,
        ST_PASSTHRU,
        ST_HALT
    } state_t;

    state_t curr_state;
    state_t next_state;

    // Output register and the one spare slot
    T_PAYLOAD out_data_reg;
    T_PAYLOAD skid_reg;

    T_PAYLOAD next_out_data;
    T_PAYLOAD next_skid_reg;
    logic     next_out_valid;
    logic     next_in_ready;

    logic     in_fire;

    // Registered ready already tells whether an item is accepted
    assign in_fire = i_in_valid && o_in_ready;

    always_comb begin
        next_state     = curr_state;
        next_out_data  = out_data_reg;
        next_out_valid = o_out_valid;
        next_skid_reg  = skid_reg;
        next_in_ready  = o_in_ready;

        case (curr_state)
            ST_START: begin
                // Ready rises one cycle after reset is released
                next_in_ready = 1'b1;
                next_state    = ST_IDLE;
            end
            ST_IDLE: begin
                if (in_fire) begin
                    next_out_data  = i_in_data;
                    next_out_valid = 1'b1;
                    next_state     = ST_PASSTHRU;
                end
            end
            ST_PASSTHRU: begin
                case ({i_out_ready, in_fire})
                    2'b11: begin
                        // Output drained and refilled on the same edge
                        next_out_data = i_in_data;
                    end
                    2'b10: begin
                        next_out_valid = 1'b0;
                        next_state     = ST_IDLE;
                    end
                    2'b01: begin
                        // Park the arriving item while the output stalls
                        next_skid_reg = i_in_data;
                        next_in_ready = 1'b0;
                        next_state    = ST_HALT;
                    end
                    default: begin
                        next_state = ST_PASSTHRU;
                    end
                endcase
            end
            ST_HALT: begin
                if (i_out_ready) begin
                    next_out_data = skid_reg;
                    next_in_ready = 1'b1;
                    next_state    = ST_PASSTHRU;
                end
            end
            default: begin
                next_out_valid = 1'b0;
                next_in_ready  = 1'b0;
                next_state     = ST_START;
            end
        endcase
    end

    // Control state
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            curr_state  <= ST_START;
            o_out_valid <= 1'b0;
            o_in_ready  <= 1'b0;
        end else begin
            curr_state  <= next_state;
            o_out_valid <= next_out_valid;
            o_in_ready  <= next_in_ready;
        end
    end

    // Payload registers
    always_ff @(posedge i_clock) begin
        out_data_reg <= next_out_data;
        skid_reg     <= next_skid_reg;
    end

    assign o_out_data = out_data_reg;

    // Held output under back-pressure
    a_out_stable: assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_out_valid && !i_out_ready) |=> $stable(o_out_data)
    );

    // Nothing offered in the cycle after reset is released
    a_out_idle_after_reset: assert property (
        @(posedge i_clock)
        $fell(i_reset) |=> !o_out_valid
    );

endmodule
